// File: huff_pkg.sv
package huff_pkg;

    // symbol leaves take the low slots and internal nodes follow them
    localparam int num_leaves = 256;
    localparam int num_slots  = 384;
    localparam int slot_w     = 9;

    // a table entry, whose slot index is just {is_node, idx}
    typedef struct packed {
        logic       is_node;
        logic [7:0] idx;
    } slot_ref_t;

    // one merge step of the tree
    typedef struct packed {
        slot_ref_t   least1; // smaller count
        slot_ref_t   least2; // second smallest count
        slot_ref_t   parent; // node that now holds the sum
        logic [63:0] sum;    // zero extended from the table's count width
    } merge_rec_t;

    typedef enum logic [2:0] {
        st_count, // idle, symbols are counted
        st_clear, // reset the scan counter and finder before a pass
        st_scan,  // one slot per cycle
        st_merge, // wipe the pair and write the new node
        st_done   // tree finished
    } ctrl_state_t;

endpackage

// File: freq_table.sv
module freq_table #(
    parameter int count_w = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    // symbol counting
    input  logic                          inc_en,
    input  logic [7:0]                    inc_sym,
    // scan port
    input  logic [huff_pkg::slot_w-1:0]   rd_slot,
    output logic [count_w-1:0]            rd_data,
    // node write
    input  logic                          wr_en,
    input  logic [huff_pkg::slot_w-1:0]   wr_slot,
    input  logic [count_w-1:0]            wr_data,
    // the pair that was just merged
    input  logic                          wipe_en,
    input  huff_pkg::slot_ref_t           wipe_a,
    input  huff_pkg::slot_ref_t           wipe_b
);

    logic [count_w-1:0]          counts [huff_pkg::num_slots];
    logic [huff_pkg::slot_w-1:0] inc_slot;
    logic [huff_pkg::slot_w-1:0] wipe_a_slot;
    logic [huff_pkg::slot_w-1:0] wipe_b_slot;

    assign inc_slot    = {1'b0, inc_sym};                 // symbols only ever touch leaves
    assign wipe_a_slot = {wipe_a.is_node, wipe_a.idx};
    assign wipe_b_slot = {wipe_b.is_node, wipe_b.idx};

    // scan reads are combinational so the finder sees one slot per cycle
    assign rd_data = counts[rd_slot];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int i = 0; i < huff_pkg::num_slots; i++) begin
                counts[i] <= '0;
            end
        end else begin
            if (inc_en) begin
                counts[inc_slot] <= counts[inc_slot] + count_w'(1);
            end
            // wipes come before the node write so a reused slot keeps the sum
            if (wipe_en) begin
                counts[wipe_a_slot] <= '0;
                counts[wipe_b_slot] <= '0;
            end
            if (wr_en) begin
                counts[wr_slot] <= wr_data;
            end
        end
    end

endmodule

// File: scan_counter.sv
module scan_counter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear,
    input  logic                        run,
    output logic [huff_pkg::slot_w-1:0] idx,
    output logic                        pass_end
);

    localparam int                        last_int  = huff_pkg::num_slots - 1;
    localparam logic [huff_pkg::slot_w-1:0] last_slot = last_int[huff_pkg::slot_w-1:0];

    logic at_last;

    assign at_last  = (idx == last_slot);
    assign pass_end = run && at_last; // the controller leaves the scan on this

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            idx <= '0;
        end else if (clear) begin
            idx <= '0;
        end else if (run) begin
            // wrap so a pass that is not cleared still starts from slot 0
            if (at_last) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

endmodule

// File: least_pair_finder.sv
module least_pair_finder #(
    parameter int count_w = 64
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear,
    input  logic                        scan_en,
    input  logic [huff_pkg::slot_w-1:0] idx,
    input  logic [count_w-1:0]          comp_val,
    output huff_pkg::slot_ref_t         least1,
    output huff_pkg::slot_ref_t         least2,
    output logic [count_w-1:0]          sum,
    output logic                        pair_found
);

    localparam int                          leaf_int  = huff_pkg::num_leaves;
    localparam logic [huff_pkg::slot_w-1:0] leaf_base = leaf_int[huff_pkg::slot_w-1:0];

    logic [count_w-1:0]          val1;
    logic [count_w-1:0]          val2;
    logic [count_w-1:0]          val1_n;
    logic [count_w-1:0]          val2_n;
    huff_pkg::slot_ref_t         least1_n;
    huff_pkg::slot_ref_t         least2_n;
    huff_pkg::slot_ref_t         cur_ref;
    logic [huff_pkg::slot_w-1:0] node_off;

    // slots past the leaves turn into node references
    assign node_off = idx - leaf_base;

    always_comb begin
        cur_ref.is_node = (idx >= leaf_base);
        if (cur_ref.is_node) begin
            cur_ref.idx = node_off[7:0];
        end else begin
            cur_ref.idx = idx[7:0];
        end
    end

    // strict compares mean an earlier slot keeps its place on a tie
    always_comb begin
        val1_n   = val1;
        val2_n   = val2;
        least1_n = least1;
        least2_n = least2;
        if (comp_val != '0) begin
            if (comp_val < val1) begin
                val2_n   = val1;   // old minimum drops to second place
                least2_n = least1;
                val1_n   = comp_val;
                least1_n = cur_ref;
            end else if (comp_val < val2) begin
                val2_n   = comp_val;
                least2_n = cur_ref;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            val1   <= '1;
            val2   <= '1;
            least1 <= '0;
            least2 <= '0;
        end else if (clear) begin
            val1   <= '1;
            val2   <= '1;
            least1 <= '0;
            least2 <= '0;
        end else if (scan_en) begin
            val1   <= val1_n;
            val2   <= val2_n;
            least1 <= least1_n;
            least2 <= least2_n;
        end
    end

    assign sum        = val1 + val2;
    assign pair_found = (val2 != '1); // a second nonzero entry was seen

endmodule

// File: tree_ctrl.sv
module tree_ctrl #(
    parameter int count_w = 64
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        build,
    // scan and finder results
    input  logic                        pass_end,
    input  logic                        pair_found,
    input  huff_pkg::slot_ref_t         least1,
    input  huff_pkg::slot_ref_t         least2,
    input  logic [count_w-1:0]          sum,
    // pass control
    output logic                        clear,
    output logic                        run,
    output logic                        scan_en,
    // table update
    output logic                        wr_en,
    output logic [huff_pkg::slot_w-1:0] wr_slot,
    output logic [count_w-1:0]          wr_data,
    output logic                        wipe_en,
    // status and results
    output logic                        busy,
    output logic                        merge_valid,
    output huff_pkg::merge_rec_t        merge,
    output logic                        done
);

    huff_pkg::ctrl_state_t state;
    huff_pkg::ctrl_state_t state_n;
    huff_pkg::slot_ref_t   parent;
    logic [7:0]            fresh_idx;
    logic                  fresh_use;
    logic                  merging;

    always_comb begin
        state_n = state;
        case (state)
            huff_pkg::st_count: if (build) state_n = huff_pkg::st_clear;
            huff_pkg::st_clear: state_n = huff_pkg::st_scan;
            huff_pkg::st_scan:  if (pass_end) state_n = huff_pkg::st_merge;
            huff_pkg::st_merge: begin
                // no pair left means the last node is the root
                state_n = pair_found ? huff_pkg::st_clear : huff_pkg::st_done;
            end
            default:            state_n = huff_pkg::st_count;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= huff_pkg::st_count;
        end else begin
            state <= state_n;
        end
    end

    // a node already in the pair gives up its slot to the parent
    always_comb begin
        fresh_use = 1'b0;
        if (least1.is_node) begin
            parent = least1;
        end else if (least2.is_node) begin
            parent = least2;
        end else begin
            parent    = '{is_node: 1'b1, idx: fresh_idx};
            fresh_use = 1'b1;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            fresh_idx <= '0;
        end else if (state == huff_pkg::st_count && build) begin
            fresh_idx <= '0;                            // each tree numbers its nodes anew
        end else if (merging && fresh_use) begin
            fresh_idx <= fresh_idx + 1'b1;
        end
    end

    assign merging = (state == huff_pkg::st_merge) && pair_found;

    assign clear   = (state == huff_pkg::st_clear);
    assign run     = (state == huff_pkg::st_scan);
    assign scan_en = (state == huff_pkg::st_scan);
    assign busy    = (state != huff_pkg::st_count);

    assign wr_en   = merging;
    assign wipe_en = merging;
    assign wr_slot = {parent.is_node, parent.idx};
    assign wr_data = sum;

    assign merge_valid = merging;
    assign done        = (state == huff_pkg::st_merge) && !pair_found;

    always_comb begin
        merge.least1 = least1;
        merge.least2 = least2;
        merge.parent = parent;
        merge.sum    = 64'(sum);
    end

endmodule

// File: huff_tree_builder.sv
module huff_tree_builder #(
    parameter int count_w = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sym_valid,
    input  logic [7:0]           sym,
    input  logic                 build,
    output logic                 busy,
    output logic                 merge_valid,
    output huff_pkg::merge_rec_t merge,
    output logic                 done
);

    logic                        inc_en;
    logic                        clear;
    logic                        run;
    logic                        scan_en;
    logic                        pass_end;
    logic                        pair_found;
    logic [huff_pkg::slot_w-1:0] idx;
    logic [count_w-1:0]          rd_data;
    logic [count_w-1:0]          sum;
    logic                        wr_en;
    logic [huff_pkg::slot_w-1:0] wr_slot;
    logic [count_w-1:0]          wr_data;
    logic                        wipe_en;
    huff_pkg::slot_ref_t         least1;
    huff_pkg::slot_ref_t         least2;

    assign inc_en = sym_valid && !busy; // symbols arriving during a build are lost

    freq_table #(.count_w(count_w)) freq_table_inst (
        .clk(clk), .rst(rst),
        .inc_en(inc_en), .inc_sym(sym),
        .rd_slot(idx), .rd_data(rd_data),
        .wr_en(wr_en), .wr_slot(wr_slot), .wr_data(wr_data),
        .wipe_en(wipe_en), .wipe_a(least1), .wipe_b(least2)
    );

    scan_counter scan_counter_inst (
        .clk(clk), .rst(rst), .clear(clear), .run(run),
        .idx(idx), .pass_end(pass_end)
    );

    least_pair_finder #(.count_w(count_w)) least_pair_finder_inst (
        .clk(clk), .rst(rst), .clear(clear), .scan_en(scan_en),
        .idx(idx), .comp_val(rd_data),
        .least1(least1), .least2(least2),
        .sum(sum), .pair_found(pair_found)
    );

    tree_ctrl #(.count_w(count_w)) tree_ctrl_inst (
        .clk(clk), .rst(rst), .build(build),
        .pass_end(pass_end), .pair_found(pair_found),
        .least1(least1), .least2(least2), .sum(sum),
        .clear(clear), .run(run), .scan_en(scan_en),
        .wr_en(wr_en), .wr_slot(wr_slot), .wr_data(wr_data), .wipe_en(wipe_en),
        .busy(busy), .merge_valid(merge_valid), .merge(merge), .done(done)
    );

endmodule

// File: huff_chk.sv
module huff_chk #(
    parameter int count_w = 64
) (
    input logic               clk,
    input logic               rst,
    input logic               merge_valid,
    input logic               done,
    input logic               pass_end,
    input logic               pair_found,
    input logic [count_w-1:0] val1,
    input logic [count_w-1:0] val2
);

    timeunit 1ns;
    timeprecision 1ns;

    merge_done_excl: assert property (@(posedge clk) disable iff (rst) !(merge_valid && done))
        else $error("merge_valid and done are high in the same cycle");

    merge_after_pass: assert property (@(posedge clk) disable iff (rst)
        merge_valid |-> $past(pass_end))
        else $error("merge_valid without pass_end in the cycle before");

    // every pass ends in either a merge or completion
    pass_outcome: assert property (@(posedge clk) disable iff (rst)
        pass_end |=> (merge_valid || done))
        else $error("pass ended with neither merge_valid nor done");

    pair_order: assert property (@(posedge clk) disable iff (rst) pair_found |-> (val1 <= val2))
        else $error("least1 count is larger than least2 count");

endmodule

// the controller holds no counts, so its value inputs stay at zero
bind tree_ctrl huff_chk #(.count_w(count_w)) ctrl_chk_inst (
    .clk(clk), .rst(rst), .merge_valid(merge_valid), .done(done),
    .pass_end(pass_end), .pair_found(1'b0), .val1('0), .val2('0)
);

bind least_pair_finder huff_chk #(.count_w(count_w)) finder_chk_inst (
    .clk(clk), .rst(rst), .merge_valid(1'b0), .done(1'b0),
    .pass_end(1'b0), .pair_found(pair_found), .val1(val1), .val2(val2)
);

// File: huff_tb.sv
module huff_tb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int count_w        = 64;
    localparam int timeout_cycles = 500;

    logic                 clk;
    logic                 rst;
    logic                 sym_valid;
    logic [7:0]           sym;
    logic                 build;
    logic                 busy;
    logic                 merge_valid;
    huff_pkg::merge_rec_t merge;
    logic                 done;

    integer               seed = 80;
    int                   value_errs;
    int                   other_errs;
    logic [count_w-1:0]   model_cnt [huff_pkg::num_slots];
    logic [63:0]          total_cnt; // accepted symbols since the last reset
    huff_pkg::merge_rec_t exp_q [$];

    huff_tree_builder #(.count_w(count_w)) huff_tree_builder_inst (
        .clk(clk), .rst(rst), .sym_valid(sym_valid), .sym(sym), .build(build),
        .busy(busy), .merge_valid(merge_valid), .merge(merge), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic clear_model();
        for (int i = 0; i < huff_pkg::num_slots; i++) begin
            model_cnt[i] = '0;
        end
        total_cnt = '0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst       <= 1'b1;
        sym_valid <= 1'b0;
        build     <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        clear_model();
    endtask

    task automatic send_sym(input logic [7:0] s);
        @(posedge clk);
        sym_valid <= 1'b1;
        sym       <= s;
        model_cnt[{1'b0, s}] = model_cnt[{1'b0, s}] + count_w'(1); // leaves sit at the symbol
        total_cnt = total_cnt + 64'(1);
    endtask

    // symbols and build strobes thrown at the DUT while it is busy
    task automatic drive_noise(input bit en);
        logic [31:0] rnd;
        rnd = $random(seed);
        if (en) begin
            sym_valid <= rnd[0];
            sym       <= rnd[15:8];
            build     <= (rnd[20:18] == 3'd0);
        end else begin
            sym_valid <= 1'b0;
            build     <= 1'b0;
        end
    endtask

    function automatic huff_pkg::slot_ref_t to_ref(input int slot);
        huff_pkg::slot_ref_t r;
        r.is_node = (slot >= huff_pkg::num_leaves);
        if (r.is_node) begin
            r.idx = 8'(slot - huff_pkg::num_leaves);
        end else begin
            r.idx = 8'(slot);
        end
        return r;
    endfunction

    function automatic bit nodes_empty();
        bit empty;
        empty = 1'b1;
        for (int i = huff_pkg::num_leaves; i < huff_pkg::num_slots; i++) begin
            if (model_cnt[i] != '0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    // runs every pass of a build on the model table and queues the records
    task automatic predict_build();
        logic [count_w-1:0]   v1;
        logic [count_w-1:0]   v2;
        int                   s1;
        int                   s2;
        int                   parent;
        int                   fresh;
        bit                   found;
        huff_pkg::merge_rec_t rec;
        exp_q.delete();
        fresh = 0;
        found = 1'b1;
        while (found) begin
            v1 = '1;
            v2 = '1;
            s1 = 0;
            s2 = 0;
            for (int i = 0; i < huff_pkg::num_slots; i++) begin
                if (model_cnt[i] != '0) begin
                    if (model_cnt[i] < v1) begin
                        v2 = v1;
                        s2 = s1;
                        v1 = model_cnt[i];
                        s1 = i;
                    end else if (model_cnt[i] < v2) begin
                        v2 = model_cnt[i];
                        s2 = i;
                    end
                end
            end
            found = (v2 != '1);
            if (found) begin
                if (s1 >= huff_pkg::num_leaves) begin
                    parent = s1;
                end else if (s2 >= huff_pkg::num_leaves) begin
                    parent = s2;
                end else begin
                    parent = huff_pkg::num_leaves + fresh;
                    fresh++;
                end
                rec.least1 = to_ref(s1);
                rec.least2 = to_ref(s2);
                rec.parent = to_ref(parent);
                rec.sum    = 64'(v1 + v2);
                exp_q.push_back(rec);
                model_cnt[s1]     = '0;
                model_cnt[s2]     = '0;
                model_cnt[parent] = v1 + v2; // after the wipes, so a reused slot keeps it
            end
        end
    endtask

    task automatic check_merge(input huff_pkg::merge_rec_t got, input huff_pkg::merge_rec_t want);
        if (got.least1 !== want.least1) begin
            $display("ERR merge.least1 got %h exp %h", got.least1, want.least1);
            value_errs++;
        end
        if (got.least2 !== want.least2) begin
            $display("ERR merge.least2 got %h exp %h", got.least2, want.least2);
            value_errs++;
        end
        if (got.parent !== want.parent) begin
            $display("ERR merge.parent got %h exp %h", got.parent, want.parent);
            value_errs++;
        end
        if (got.sum !== want.sum) begin
            $display("ERR merge.sum got %h exp %h", got.sum, want.sum);
            value_errs++;
        end
    endtask

    task automatic check_count(input int got, input int want);
        if (got != want) begin
            $display("ERR merge_count got %h exp %h", got, want);
            value_errs++;
        end
    endtask

    task automatic check_sum(input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            $display("ERR root merge.sum got %h exp %h", got, want);
            value_errs++;
        end
    endtask

    task automatic check_busy(input logic got, input logic want);
        if (got !== want) begin
            $display("ERR busy got %h exp %h", got, want);
            value_errs++;
        end
    endtask

    task automatic run_build(input bit noise);
        int          got_merges;
        int          want_merges;
        int          wait_cnt;
        bit          seen;
        bit          finished;
        bit          root_check;
        logic [63:0] last_sum;
        got_merges  = 0;
        last_sum    = '0;
        finished    = 1'b0;
        seen        = 1'b0;
        root_check  = nodes_empty(); // the root only equals the total on a table without nodes
        predict_build();
        want_merges = exp_q.size();
        @(posedge clk);
        sym_valid <= 1'b0;
        build     <= 1'b1;
        @(posedge clk);
        drive_noise(noise);
        while (!finished) begin
            wait_cnt = 0;
            seen     = 1'b0;
            while (!seen && wait_cnt < timeout_cycles) begin
                @(negedge clk);
                check_busy(busy, 1'b1); // every cycle from st_clear to st_merge is busy
                if (merge_valid || done) begin
                    seen = 1'b1;
                end else begin
                    wait_cnt++;
                    @(posedge clk);
                    drive_noise(noise);
                end
            end
            if (!seen) begin
                $display("timeout: no merge and no done within %0d cycles", timeout_cycles);
                other_errs++;
                finished = 1'b1;
            end else begin
                if (merge_valid) begin
                    got_merges++;
                    last_sum = merge.sum;
                    if (exp_q.size() == 0) begin
                        $display("a merge arrived that the model did not predict");
                        other_errs++;
                    end else begin
                        check_merge(merge, exp_q.pop_front());
                    end
                end
                if (done) begin
                    finished = 1'b1;
                end
                @(posedge clk);
                drive_noise(noise && !finished);
            end
        end
        if (seen) begin
            check_count(got_merges, want_merges);
            if (root_check && got_merges > 0) begin
                check_sum(last_sum, total_cnt);
            end
            wait_cnt = 0;
            @(negedge clk);
            while (busy && wait_cnt < timeout_cycles) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (busy) begin
                $display("timeout: busy stayed high after done");
                other_errs++;
            end
        end
    endtask

    initial begin
        int          n;
        int          alpha;
        int          k;
        int          fib_cnt [6];
        logic [7:0]  base;
        logic [31:0] rnd;
        rst        = 1'b1;
        sym_valid  = 1'b0;
        sym        = '0;
        build      = 1'b0;
        value_errs = 0;
        other_errs = 0;
        fib_cnt    = '{1, 1, 2, 3, 5, 8};
        clear_model();
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // an empty table and then a single symbol both end without a merge
        run_build(1'b0);
        for (int i = 0; i < 5; i++) begin
            send_sym(8'h07);
        end
        run_build(1'b0);

        // equal counts that arrive out of slot order
        apply_reset();
        for (int i = 0; i < 3; i++) begin
            send_sym(8'h90);
            send_sym(8'h10);
            send_sym(8'h40);
            send_sym(8'h20);
        end
        run_build(1'b0);

        apply_reset();
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < fib_cnt[i]; j++) begin
                send_sym(8'(i + 1)); // chains leaves onto one growing node
            end
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 20; j++) begin
                send_sym(8'(8'ha0 + i)); // equal leaves that end in node with node merges
            end
        end
        run_build(1'b0);

        // random alphabets, later rounds count on top of the previous root
        apply_reset();
        for (int r = 0; r < 3; r++) begin
            rnd   = $random(seed);
            alpha = 2 + int'(rnd[2:0]);
            base  = rnd[15:8];
            n     = 20 + int'(rnd[21:16]);
            for (int i = 0; i < n; i++) begin
                rnd = $random(seed);
                k   = int'(rnd[15:0]) % alpha;
                send_sym(base + 8'(k));
                if (rnd[16]) begin
                    @(posedge clk);
                    sym_valid <= 1'b0;
                end
            end
            run_build(r != 0);
        end

        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
huff_pkg.sv
freq_table.sv
scan_counter.sv
least_pair_finder.sv
tree_ctrl.sv
huff_tree_builder.sv
huff_chk.sv
huff_tb.sv

// File: Makefile
# Verilator build and run for the Huffman tree builder

VERILATOR  ?= verilator
TOP        ?= huff_tb
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= CHECKS FAILED
PASS_MSG   ?= ALL CHECKS PASSED
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ns
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
